// ==== tb.f ====
+incdir+.
accel_pkg.sv
databus_if.sv
address_gen.sv
burst_reader.sv
local_buffer.sv
vread_unit.sv
databus_arbiter.sv
accel_top.sv
tb_clock.sv
tb_accel_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_accel_top
RTL_TOP    ?= accel_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_accel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_cfg.svh"

module tb_accel_top;
   import accel_pkg::*;

   localparam logic [31:0] SEED = 32'h84e92acd;
   localparam int PP_BIT = `ACCEL_BUF_ADDR_W - 1;
   localparam int DEPTH = 1 << `ACCEL_BUF_ADDR_W;
   localparam int MAX_OUT = 64;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_RUNS = 21;
   // longest burst of each unit with a gap of 3 per word, then playback
   localparam int WORST_RUN = `ACCEL_NUM_UNITS * 255 * 4 + MAX_OUT + 16;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_RUNS + 1) * WORST_RUN;

   logic      clk;
   logic      rst;
   logic      run;
   logic      done;
   logic      bus_req;
   ext_addr_t bus_addr;
   len_t      bus_len;
   logic      bus_ready;
   word_t     bus_rdata;
   logic      bus_last;
   logic      out_valid [2];
   word_t     out_data [2];

   // values on the DUT configuration ports
   logic      en_d [2];
   logic      pp_d [2];
   ext_addr_t ext_d [2];
   len_t      len_d [2];
   buf_addr_t start_d [2];
   buf_addr_t incr_d [2];
   buf_addr_t shift_d [2];
   loop_t     per_d [2];
   loop_t     iter_d [2];

   // configuration of the next run, as the model sees it
   logic      cfg_en [2];
   logic      cfg_pp [2];
   ext_addr_t cfg_ext [2];
   len_t      cfg_len [2];
   buf_addr_t cfg_start [2];
   buf_addr_t cfg_incr [2];
   buf_addr_t cfg_shift [2];
   loop_t     cfg_per [2];
   loop_t     cfg_iter [2];

   word_t     model_buf [2][DEPTH];
   logic      model_pp [2];
   word_t     exp_w [2][MAX_OUT];
   int        exp_n [2];
   word_t     got_w [2][MAX_OUT];
   int        got_n [2];
   int        gap_tab [512];
   int        burst_cnt;
   logic      gaps_on;
   int        seed;
   int        errors;
   int        test_errs;
   int        tests_run;
   int        tests_bad;
   int        cycle_cnt;
   string     test_name;

   tb_clock clock_inst (
      .clk_o (clk)
   );

   accel_top accel_top_inst (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run),
      .bus_req_o    (bus_req),
      .bus_addr_o   (bus_addr),
      .bus_len_o    (bus_len),
      .bus_ready_i  (bus_ready),
      .bus_rdata_i  (bus_rdata),
      .bus_last_i   (bus_last),
      .enable0_i    (en_d[0]),
      .pingpong0_i  (pp_d[0]),
      .ext_addr0_i  (ext_d[0]),
      .length0_i    (len_d[0]),
      .start0_i     (start_d[0]),
      .incr0_i      (incr_d[0]),
      .shift0_i     (shift_d[0]),
      .per0_i       (per_d[0]),
      .iter0_i      (iter_d[0]),
      .enable1_i    (en_d[1]),
      .pingpong1_i  (pp_d[1]),
      .ext_addr1_i  (ext_d[1]),
      .length1_i    (len_d[1]),
      .start1_i     (start_d[1]),
      .incr1_i      (incr_d[1]),
      .shift1_i     (shift_d[1]),
      .per1_i       (per_d[1]),
      .iter1_i      (iter_d[1]),
      .out_valid0_o (out_valid[0]),
      .out_data0_o  (out_data[0]),
      .out_valid1_o (out_valid[1]),
      .out_data1_o  (out_data[1]),
      .done_o       (done)
   );

   function automatic int pick(int lo, int hi);
      int r;
      r = $random(seed);
      return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
   endfunction

   // external memory content
   function automatic word_t mem_word(ext_addr_t a);
      return a * 32'd3 + 32'h1000;
   endfunction

   task automatic check_word(string what, word_t exp, word_t act);
      if (exp !== act) begin
         $display("Error: test %s, %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic check_count(string what, loop_t exp, loop_t act);
      if (exp !== act) begin
         $display("Error: test %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   // answers one granted burst at a time
   initial begin : memory_model
      ext_addr_t base;
      int        n;
      int        idx;
      bus_ready = 1'b0;
      bus_rdata = '0;
      bus_last  = 1'b0;
      burst_cnt = 0;
      forever begin
         @(negedge clk);
         if (bus_req) begin
            base = bus_addr;
            n    = int'(bus_len);
            for (int k = 0; k < n; k++) begin
               idx = k + 256 * (burst_cnt % 2);
               repeat (gap_tab[idx]) begin
                  @(posedge clk);
                  bus_ready <= 1'b0;
                  bus_last  <= 1'b0;
               end
               @(posedge clk);
               bus_ready <= 1'b1;
               bus_rdata <= mem_word(base + ext_addr_t'(4 * k));
               bus_last  <= (k == n - 1);
            end
            @(posedge clk);
            bus_ready <= 1'b0;
            bus_last  <= 1'b0;
            burst_cnt++;
         end
      end
   end

   always @(negedge clk) begin
      if (run) begin
         got_n[0] = 0;
         got_n[1] = 0;
      end else begin
         for (int u = 0; u < 2; u++) begin
            if (out_valid[u]) begin
               if (got_n[u] < MAX_OUT) begin
                  got_w[u][got_n[u]] = out_data[u];
               end
               got_n[u]++;
            end
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: done_o did not rise within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

   task automatic set_fetch(int u, logic en, logic pp, int len, logic fresh);
      cfg_en[u]  = en;
      cfg_pp[u]  = pp;
      cfg_len[u] = len_t'(len);
      if (fresh) begin
         cfg_ext[u] = {$random(seed)} & 32'hffff_fffc;
      end
   endtask

   task automatic set_loops(int u, int lo);
      cfg_start[u] = buf_addr_t'(pick(0, 255));
      cfg_incr[u]  = buf_addr_t'(pick(0, 255));
      cfg_shift[u] = buf_addr_t'(pick(0, 255));
      cfg_per[u]   = loop_t'(pick(lo, 8));
      cfg_iter[u]  = loop_t'(pick(lo, 7));
   endtask

   // expected playback from the buffer before this run, then the burst writes
   task automatic model_run(int u);
      buf_addr_t a;
      buf_addr_t rd;
      buf_addr_t wa;
      int        n;
      model_pp[u] = cfg_pp[u] ? ~model_pp[u] : 1'b0;
      a = cfg_start[u];
      n = 0;
      for (int o = 0; o < int'(cfg_iter[u]); o++) begin
         for (int i = 0; i < int'(cfg_per[u]); i++) begin
            rd = cfg_pp[u] ? {model_pp[u], a[PP_BIT-1:0]} : a;
            exp_w[u][n] = model_buf[u][rd];
            n++;
            if (i < int'(cfg_per[u]) - 1) begin
               a = a + cfg_incr[u];
            end else if (o < int'(cfg_iter[u]) - 1) begin
               a = a + cfg_shift[u];
            end
         end
      end
      exp_n[u] = n;
      if (cfg_en[u] && cfg_len[u] != '0) begin
         for (int k = 0; k < int'(cfg_len[u]); k++) begin
            wa = buf_addr_t'(k);
            if (cfg_pp[u]) begin
               wa[PP_BIT] = ~model_pp[u];
            end
            model_buf[u][wa] = mem_word(cfg_ext[u] + ext_addr_t'(4 * k));
         end
      end
   endtask

   task automatic run_and_check();
      int exp_bursts;
      int bursts_before;
      int got;
      exp_bursts = 0;
      for (int k = 0; k < 512; k++) begin
         gap_tab[k] = gaps_on ? pick(0, 3) : 0;
      end
      for (int u = 0; u < 2; u++) begin
         if (cfg_en[u] && cfg_len[u] != '0) begin
            exp_bursts++;
         end
         model_run(u);
      end
      bursts_before = burst_cnt;
      @(posedge clk);
      for (int u = 0; u < 2; u++) begin
         en_d[u]    <= cfg_en[u];
         pp_d[u]    <= cfg_pp[u];
         ext_d[u]   <= cfg_ext[u];
         len_d[u]   <= cfg_len[u];
         start_d[u] <= cfg_start[u];
         incr_d[u]  <= cfg_incr[u];
         shift_d[u] <= cfg_shift[u];
         per_d[u]   <= cfg_per[u];
         iter_d[u]  <= cfg_iter[u];
      end
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      while (!done) begin
         @(negedge clk);
      end
      // the last output word can share its cycle with done
      @(negedge clk);
      for (int u = 0; u < 2; u++) begin
         got = (got_n[u] > MAX_OUT - 1) ? MAX_OUT - 1 : got_n[u];
         check_count($sformatf("unit%0d output count", u), loop_t'(exp_n[u]), loop_t'(got));
         for (int k = 0; k < exp_n[u] && k < got_n[u]; k++) begin
            check_word($sformatf("unit%0d word %0d", u, k), exp_w[u][k], got_w[u][k]);
         end
      end
      check_count("burst count", loop_t'(exp_bursts), loop_t'(burst_cnt - bursts_before));
   endtask

   task automatic begin_test(string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("%-14s ok", test_name);
      end else begin
         tests_bad++;
         $display("%-14s FAIL, %0d errors", test_name, test_errs);
      end
   endtask

   initial begin : main
      seed      = SEED;
      errors    = 0;
      tests_run = 0;
      tests_bad = 0;
      gaps_on   = 1'b1;
      rst       = 1'b1;
      run       = 1'b0;
      for (int u = 0; u < 2; u++) begin
         en_d[u]     = 1'b0;
         pp_d[u]     = 1'b0;
         ext_d[u]    = '0;
         len_d[u]    = '0;
         start_d[u]  = '0;
         incr_d[u]   = '0;
         shift_d[u]  = '0;
         per_d[u]    = '0;
         iter_d[u]   = '0;
         model_pp[u] = 1'b0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // both halves of both buffers get known words, no playback yet
      begin_test("fill");
      for (int r = 0; r < 2; r++) begin
         for (int u = 0; u < 2; u++) begin
            set_fetch(u, 1'b1, 1'b1, 128, 1'b1);
            set_loops(u, 0);
            cfg_per[u] = '0;
         end
         run_and_check();
      end
      end_test();

      // fetch only, then sequential playback while the same burst comes again
      begin_test("single_unit");
      set_fetch(0, 1'b1, 1'b0, pick(56, 255), 1'b1);
      set_loops(0, 0);
      cfg_per[0] = '0;
      set_fetch(1, 1'b0, 1'b0, 0, 1'b0);
      set_loops(1, 0);
      run_and_check();
      set_loops(0, 1);
      cfg_start[0] = '0;
      cfg_incr[0]  = 8'd1;
      cfg_shift[0] = 8'd1;
      run_and_check();
      end_test();

      begin_test("two_level");
      for (int r = 0; r < 4; r++) begin
         for (int u = 0; u < 2; u++) begin
            set_fetch(u, 1'b0, 1'b0, pick(0, 255), 1'b1);
            set_loops(u, 1);
         end
         run_and_check();
      end
      end_test();

      begin_test("ping_pong");
      for (int r = 0; r < 4; r++) begin
         set_fetch(0, 1'b1, 1'b1, pick(1, 128), 1'b1);
         set_loops(0, 1);
         set_fetch(1, 1'b0, 1'b0, 0, 1'b0);
         set_loops(1, 0);
         run_and_check();
      end
      end_test();

      begin_test("shared_bus");
      for (int r = 0; r < 4; r++) begin
         for (int u = 0; u < 2; u++) begin
            set_fetch(u, 1'b1, 1'b1, pick(1, 128), 1'b1);
            set_loops(u, 1);
         end
         run_and_check();
      end
      end_test();

      begin_test("no_fetch");
      set_fetch(0, 1'b1, 1'b0, 0, 1'b1);
      set_loops(0, 1);
      set_fetch(1, 1'b0, 1'b0, pick(1, 128), 1'b1);
      set_loops(1, 1);
      run_and_check();
      set_fetch(0, 1'b1, 1'b1, 0, 1'b1);
      set_loops(0, 0);
      cfg_per[0] = '0;
      set_fetch(1, 1'b0, 1'b1, pick(1, 128), 1'b1);
      set_loops(1, 1);
      run_and_check();
      end_test();

      // same playback without gaps and with gaps
      begin_test("back_pressure");
      for (int u = 0; u < 2; u++) begin
         set_fetch(u, 1'b1, 1'b0, pick(1, 255), 1'b1);
         set_loops(u, 0);
         cfg_per[u] = '0;
      end
      run_and_check();
      for (int u = 0; u < 2; u++) begin
         set_loops(u, 1);
      end
      gaps_on = 1'b0;
      run_and_check();
      gaps_on = 1'b1;
      run_and_check();
      end_test();

      $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
               tests_run, tests_run - tests_bad, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 20
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2) clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

// ==== accel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_cfg.svh"

module accel_top (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   output logic                      bus_req_o,
   output accel_pkg::ext_addr_t      bus_addr_o,
   output accel_pkg::len_t           bus_len_o,
   input  wire                       bus_ready_i,
   input  wire accel_pkg::word_t     bus_rdata_i,
   input  wire                       bus_last_i,
   input  wire                       enable0_i,
   input  wire                       pingpong0_i,
   input  wire accel_pkg::ext_addr_t ext_addr0_i,
   input  wire accel_pkg::len_t      length0_i,
   input  wire accel_pkg::buf_addr_t start0_i,
   input  wire accel_pkg::buf_addr_t incr0_i,
   input  wire accel_pkg::buf_addr_t shift0_i,
   input  wire accel_pkg::loop_t     per0_i,
   input  wire accel_pkg::loop_t     iter0_i,
   input  wire                       enable1_i,
   input  wire                       pingpong1_i,
   input  wire accel_pkg::ext_addr_t ext_addr1_i,
   input  wire accel_pkg::len_t      length1_i,
   input  wire accel_pkg::buf_addr_t start1_i,
   input  wire accel_pkg::buf_addr_t incr1_i,
   input  wire accel_pkg::buf_addr_t shift1_i,
   input  wire accel_pkg::loop_t     per1_i,
   input  wire accel_pkg::loop_t     iter1_i,
   output logic                      out_valid0_o,
   output accel_pkg::word_t          out_data0_o,
   output logic                      out_valid1_o,
   output accel_pkg::word_t          out_data1_o,
   output logic                      done_o
);

   logic [`ACCEL_NUM_UNITS-1:0] unit_done;

   databus_if bus0_if ();
   databus_if bus1_if ();

   vread_unit vread0_inst (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .enable_i    (enable0_i),
      .pingpong_i  (pingpong0_i),
      .ext_addr_i  (ext_addr0_i),
      .length_i    (length0_i),
      .start_i     (start0_i),
      .incr_i      (incr0_i),
      .shift_i     (shift0_i),
      .per_i       (per0_i),
      .iter_i      (iter0_i),
      .bus         (bus0_if),
      .out_valid_o (out_valid0_o),
      .out_data_o  (out_data0_o),
      .done_o      (unit_done[0])
   );

   vread_unit vread1_inst (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .enable_i    (enable1_i),
      .pingpong_i  (pingpong1_i),
      .ext_addr_i  (ext_addr1_i),
      .length_i    (length1_i),
      .start_i     (start1_i),
      .incr_i      (incr1_i),
      .shift_i     (shift1_i),
      .per_i       (per1_i),
      .iter_i      (iter1_i),
      .bus         (bus1_if),
      .out_valid_o (out_valid1_o),
      .out_data_o  (out_data1_o),
      .done_o      (unit_done[1])
   );

   databus_arbiter arbiter_inst (
      .clk         (clk),
      .rst         (rst),
      .unit0       (bus0_if),
      .unit1       (bus1_if),
      .bus_req_o   (bus_req_o),
      .bus_addr_o  (bus_addr_o),
      .bus_len_o   (bus_len_o),
      .bus_ready_i (bus_ready_i),
      .bus_rdata_i (bus_rdata_i),
      .bus_last_i  (bus_last_i)
   );

   // all units finished fetch and playback
   assign done_o = &unit_done;

endmodule

`default_nettype wire

// ==== databus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module databus_arbiter (
   input  wire                       clk,
   input  wire                       rst,
   databus_if.arbiter                unit0,
   databus_if.arbiter                unit1,
   output logic                      bus_req_o,
   output accel_pkg::ext_addr_t      bus_addr_o,
   output accel_pkg::len_t           bus_len_o,
   input  wire                       bus_ready_i,
   input  wire accel_pkg::word_t     bus_rdata_i,
   input  wire                       bus_last_i
);

   logic busy;
   logic owner;
   logic last_winner;
   logic pick;
   logic grant0;
   logic grant1;

   // the side after the last winner goes first
   always_comb begin
      if (last_winner) begin
         pick = unit0.req ? 1'b0 : 1'b1;
      end else begin
         pick = unit1.req ? 1'b1 : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy        <= 1'b0;
         owner       <= 1'b0;
         last_winner <= 1'b1;
      end else if (!busy) begin
         if (unit0.req || unit1.req) begin
            busy  <= 1'b1;
            owner <= pick;
         end
      end else if (bus_ready_i && bus_last_i) begin
         // grant held for the whole burst
         busy        <= 1'b0;
         last_winner <= owner;
      end
   end

   assign grant0 = busy & ~owner;
   assign grant1 = busy & owner;

   assign bus_req_o  = owner ? grant1 & unit1.req : grant0 & unit0.req;
   assign bus_addr_o = owner ? unit1.addr : unit0.addr;
   assign bus_len_o  = owner ? unit1.len : unit0.len;

   // only the granted side sees the response
   assign unit0.ready = grant0 & bus_ready_i;
   assign unit0.rdata = grant0 ? bus_rdata_i : '0;
   assign unit0.last  = grant0 & bus_last_i;

   assign unit1.ready = grant1 & bus_ready_i;
   assign unit1.rdata = grant1 ? bus_rdata_i : '0;
   assign unit1.last  = grant1 & bus_last_i;

endmodule

`default_nettype wire

// ==== vread_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_cfg.svh"

module vread_unit (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   input  wire                       enable_i,
   input  wire                       pingpong_i,
   input  wire accel_pkg::ext_addr_t ext_addr_i,
   input  wire accel_pkg::len_t      length_i,
   input  wire accel_pkg::buf_addr_t start_i,
   input  wire accel_pkg::buf_addr_t incr_i,
   input  wire accel_pkg::buf_addr_t shift_i,
   input  wire accel_pkg::loop_t     per_i,
   input  wire accel_pkg::loop_t     iter_i,
   databus_if.requester              bus,
   output logic                      out_valid_o,
   output accel_pkg::word_t          out_data_o,
   output logic                      done_o
);
   import accel_pkg::*;

   localparam int MSB = `ACCEL_BUF_ADDR_W - 1;

   logic      pp_state;
   logic      done_q;
   logic      rd_done;
   logic      gen_valid;
   logic      gen_done;
   logic      wr_en;
   buf_addr_t gen_addr;
   buf_addr_t rd_addr;
   buf_addr_t wr_addr_raw;
   buf_addr_t wr_addr;
   word_t     wr_data;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= pingpong_i ? ~pp_state : 1'b0;
      end
   end

   // fill one half while playing the other
   assign wr_addr = pingpong_i ? {~pp_state, wr_addr_raw[MSB-1:0]} : wr_addr_raw;
   assign rd_addr = pingpong_i ? {pp_state, gen_addr[MSB-1:0]} : gen_addr;

   burst_reader reader_inst (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run_i),
      .enable_i   (enable_i),
      .ext_addr_i (ext_addr_i),
      .length_i   (length_i),
      .bus        (bus),
      .wr_en_o    (wr_en),
      .wr_addr_o  (wr_addr_raw),
      .wr_data_o  (wr_data),
      .done_o     (rd_done)
   );

   address_gen gen_inst (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .start_i (start_i),
      .incr_i  (incr_i),
      .shift_i (shift_i),
      .per_i   (per_i),
      .iter_i  (iter_i),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   local_buffer buffer_inst (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (gen_valid),
      .rd_addr_i (rd_addr),
      .rd_data_o (out_data_o)
   );

   // valid lines up with the registered read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= gen_valid;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q <= 1'b1;
      end else if (run_i) begin
         done_q <= 1'b0;
      end else if (gen_done) begin
         done_q <= 1'b1;
      end
   end

   assign done_o = rd_done & done_q;

endmodule

`default_nettype wire

// ==== local_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_cfg.svh"

module local_buffer (
   input  wire                       clk,
   input  wire                       wr_en_i,
   input  wire accel_pkg::buf_addr_t wr_addr_i,
   input  wire accel_pkg::word_t     wr_data_i,
   input  wire                       rd_en_i,
   input  wire accel_pkg::buf_addr_t rd_addr_i,
   output accel_pkg::word_t          rd_data_o
);
   import accel_pkg::*;

   localparam int DEPTH = 1 << `ACCEL_BUF_ADDR_W;

   word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // data one cycle after the read address
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== burst_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_reader (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   input  wire                       enable_i,
   input  wire accel_pkg::ext_addr_t ext_addr_i,
   input  wire accel_pkg::len_t      length_i,
   databus_if.requester              bus,
   output logic                      wr_en_o,
   output accel_pkg::buf_addr_t      wr_addr_o,
   output accel_pkg::word_t          wr_data_o,
   output logic                      done_o
);
   import accel_pkg::*;

   logic      start;
   logic      req_q;
   buf_addr_t word_cnt;
   ext_addr_t addr_q;
   len_t      len_q;

   assign start = run_i & enable_i & (length_i != '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         req_q    <= 1'b0;
         word_cnt <= '0;
      end else if (start) begin
         req_q    <= 1'b1;
         word_cnt <= '0;
      end else if (req_q && bus.ready) begin
         word_cnt <= word_cnt + 1'b1;
         if (bus.last) begin
            req_q <= 1'b0;
         end
      end
   end

   // burst address and length stay put until last
   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= ext_addr_i;
         len_q  <= length_i;
      end
   end

   assign bus.req  = req_q;
   assign bus.addr = addr_q;
   assign bus.len  = len_q;

   // each delivered word goes straight into the buffer
   assign wr_en_o   = req_q & bus.ready;
   assign wr_addr_o = word_cnt;
   assign wr_data_o = bus.rdata;

   assign done_o = ~req_q;

endmodule

`default_nettype wire

// ==== address_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module address_gen (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   input  wire accel_pkg::buf_addr_t start_i,
   input  wire accel_pkg::buf_addr_t incr_i,
   input  wire accel_pkg::buf_addr_t shift_i,
   input  wire accel_pkg::loop_t     per_i,
   input  wire accel_pkg::loop_t     iter_i,
   output logic                      valid_o,
   output accel_pkg::buf_addr_t      addr_o,
   output logic                      done_o
);
   import accel_pkg::*;

   buf_addr_t incr_q;
   buf_addr_t shift_q;
   loop_t     per_q;
   loop_t     iter_q;
   loop_t     in_cnt;
   loop_t     out_cnt;
   logic      zero_done;
   logic      in_last;
   logic      out_last;

   assign in_last  = (in_cnt == per_q - 1'b1);
   assign out_last = (out_cnt == iter_q - 1'b1);

   always_ff @(posedge clk) begin
      if (run_i) begin
         incr_q  <= incr_i;
         shift_q <= shift_i;
         per_q   <= per_i;
         iter_q  <= iter_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_o   <= 1'b0;
         zero_done <= 1'b0;
         in_cnt    <= '0;
         out_cnt   <= '0;
         addr_o    <= '0;
      end else if (run_i) begin
         // an empty loop finishes at once
         valid_o   <= (per_i != '0) && (iter_i != '0);
         zero_done <= (per_i == '0) || (iter_i == '0);
         in_cnt    <= '0;
         out_cnt   <= '0;
         addr_o    <= start_i;
      end else begin
         zero_done <= 1'b0;
         if (valid_o) begin
            if (!in_last) begin
               in_cnt <= in_cnt + 1'b1;
               addr_o <= addr_o + incr_q;
            end else if (!out_last) begin
               // wrap of the inner loop, shift from the last address
               in_cnt  <= '0;
               out_cnt <= out_cnt + 1'b1;
               addr_o  <= addr_o + shift_q;
            end else begin
               valid_o <= 1'b0;
            end
         end
      end
   end

   assign done_o = zero_done | (valid_o & in_last & out_last);

endmodule

`default_nettype wire

// ==== databus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface databus_if;
   import accel_pkg::*;

   // held by the requester until last
   logic      req;
   ext_addr_t addr;
   len_t      len;

   // one word per ready cycle
   logic      ready;
   word_t     rdata;
   logic      last;

   modport requester (
      output req, addr, len,
      input  ready, rdata, last
   );

   modport arbiter (
      input  req, addr, len,
      output ready, rdata, last
   );

endinterface

`default_nettype wire

// ==== accel_pkg.sv ====
`default_nettype none

`include "accel_cfg.svh"

package accel_pkg;

   // external byte address
   typedef logic [`ACCEL_EXT_ADDR_W-1:0] ext_addr_t;

   // bus word and output word are the same width
   typedef logic [`ACCEL_DATA_W-1:0] word_t;

   typedef logic [`ACCEL_BUF_ADDR_W-1:0] buf_addr_t;

   // burst length in words
   typedef logic [`ACCEL_LEN_W-1:0] len_t;

   // per and iter counts of the address generator
   typedef logic [`ACCEL_LOOP_W-1:0] loop_t;

endpackage

`default_nettype wire

// ==== accel_cfg.svh ====
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

// external byte address
`define ACCEL_EXT_ADDR_W 32
`define ACCEL_DATA_W 32

// buffer address, top bit selects the ping-pong half
`define ACCEL_BUF_ADDR_W 8

`define ACCEL_LEN_W 8
`define ACCEL_LOOP_W 6
`define ACCEL_NUM_UNITS 2

`endif
